// File: hist_builder.f
+incdir+rtl
rtl/sifh_data_pkg.sv
rtl/sifh_ctrl_pkg.sv
rtl/frame_counter.sv
rtl/hist_sequencer.sv
rtl/bin_bank_ram.sv
rtl/hist_readout.sv
rtl/hist_builder_top.sv
testbench/tb_hist_builder.sv

// File: testbench/tb_hist_builder.sv
`include "sifh_params.svh"

module tb_hist_builder;
    import sifh_data_pkg::*;

    localparam int HIT_NUM  = `PIXEL_NUM * `ACQ_NUM * `DATA_NUM;
    localparam int WORD_NUM = `PIXEL_NUM * `BIN_NUM;
    // budget of one frame at 8 cycles per hit and per word
    localparam int FRAME_CYC = HIT_NUM * 8 + WORD_NUM * 8;
    // five frames in total plus room for the slow consumer
    localparam int TIMEOUT_CYC = 5 * FRAME_CYC + 500;

    logic       clk;
    logic       res;
    logic       hit_req;
    hit_t       hit;
    logic       hit_ack;
    logic       out_req;
    hist_word_t out_word;
    logic       out_ack;
    logic       his_num;

    // reference histogram with two slots for overlapping frames
    int         model [2][`PIXEL_NUM][`BIN_NUM];
    // words taken by the collector in arrival order
    hist_word_t got_q [$];
    // cycles the consumer waits before acking
    int         ack_delay;
    logic [31:0] rng = 32'h4ca4_39e8;
    int         cycle;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;

    hist_builder_top hist_builder_top_i (
        .clk      (clk),
        .res      (res),
        .hit_req  (hit_req),
        .hit      (hit),
        .hit_ack  (hit_ack),
        .out_req  (out_req),
        .out_word (out_word),
        .out_ack  (out_ack),
        .his_num  (his_num)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYC) begin
            $display("timeout: no progress after %0d cycles, handshake stuck", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`BIN_W-1:0] next_bin();
        rng = xorshift32(rng);
        return rng[`BIN_W-1:0];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    // one four-phase hit that returns once ack has dropped again
    task automatic send_hit(input logic [`BIN_W-1:0] bin);
        @(posedge clk);
        hit_req <= 1'b1;
        hit.bin <= bin;
        @(posedge clk);
        while (!hit_ack) @(posedge clk);
        hit_req <= 1'b0;
        @(posedge clk);
        while (hit_ack) @(posedge clk);
    endtask

    task automatic clear_model(input int slot);
        int p;
        int b;
        for (p = 0; p < `PIXEL_NUM; p++) begin
            for (b = 0; b < `BIN_NUM; b++) begin
                model[slot][p][b] = 0;
            end
        end
    endtask

    // hits first..last-1 of a frame counted into the model
    task automatic send_hits(input int slot, input int first, input int last,
                             input bit fixed, input logic [`BIN_W-1:0] fixed_bin);
        int k;
        int p;
        logic [`BIN_W-1:0] b;
        for (k = first; k < last; k++) begin
            b = fixed ? fixed_bin : next_bin();
            // DATA_NUM hits per pixel and one pixel sweep per acquisition
            p = (k / `DATA_NUM) % `PIXEL_NUM;
            model[slot][p][b]++;
            send_hit(b);
        end
    endtask

    // consumer side of the readout
    task automatic collect_words();
        forever begin
            @(posedge clk);
            if (out_req && !out_ack) begin
                repeat (ack_delay) @(posedge clk);
                got_q.push_back(out_word);
                out_ack <= 1'b1;
                @(posedge clk);
                while (out_req) @(posedge clk);
                out_ack <= 1'b0;
            end
        end
    endtask

    task automatic wait_words(input int n);
        while (got_q.size() < n) @(posedge clk);
    endtask

    // one bank image in pixel-major and bin-minor order
    task automatic check_drain(input int slot, input logic bank, input int base);
        int p;
        int b;
        int i;
        hist_word_t w;
        for (p = 0; p < `PIXEL_NUM; p++) begin
            for (b = 0; b < `BIN_NUM; b++) begin
                i = base + p * `BIN_NUM + b;
                w = got_q[i];
                check($sformatf("out_word.bank[%0d]", i), w.bank, bank);
                check($sformatf("out_word.pixel[%0d]", i), w.pixel, p);
                check($sformatf("out_word.bin[%0d]", i), w.bin, b);
                check($sformatf("out_word.count[%0d]", i), w.count, model[slot][p][b]);
            end
        end
    endtask

    task automatic reset_values();
        int e;
        e = errors;
        @(posedge clk);
        check("hit_ack", hit_ack, 0);
        check("out_req", out_req, 0);
        check("his_num", his_num, 0);
        finish_test("reset_state", e);
    endtask

    task automatic random_frame();
        int e;
        e = errors;
        got_q.delete();
        clear_model(0);
        send_hits(0, 0, HIT_NUM, 1'b0, '0);
        wait_words(WORD_NUM);
        // idle a while so any extra word would show up
        repeat (20) @(posedge clk);
        check("word count", got_q.size(), WORD_NUM);
        check("out_req", out_req, 0);
        check_drain(0, 1'b0, 0);
        check("his_num", his_num, 1);
        finish_test("random_frame", e);
    endtask

    task automatic single_bin_frame();
        int e;
        int p;
        hist_word_t w;
        e = errors;
        got_q.delete();
        clear_model(0);
        send_hits(0, 0, HIT_NUM, 1'b1, 4'h9);
        wait_words(WORD_NUM);
        check_drain(0, 1'b1, 0);
        // every hit of a pixel lands in bin 9
        for (p = 0; p < `PIXEL_NUM; p++) begin
            w = got_q[p * `BIN_NUM + 9];
            check($sformatf("out_word.count[p%0d b9]", p), w.count, `ACQ_NUM * `DATA_NUM);
        end
        check("his_num", his_num, 0);
        finish_test("single_bin", e);
    endtask

    task automatic overlapped_slow_drain();
        int e;
        e = errors;
        got_q.delete();
        ack_delay = 4;
        clear_model(0);
        clear_model(1);
        send_hits(0, 0, HIT_NUM, 1'b0, '0);
        // first hit of the next frame while bank 0 still drains
        send_hits(1, 0, 1, 1'b0, '0);
        check("drain still running", got_q.size() < WORD_NUM, 1);
        send_hits(1, 1, HIT_NUM, 1'b0, '0);
        wait_words(2 * WORD_NUM);
        check_drain(0, 1'b0, 0);
        check_drain(1, 1'b1, WORD_NUM);
        ack_delay = 0;
        finish_test("slow_drain", e);
    endtask

    task automatic bank_reuse();
        int e;
        e = errors;
        got_q.delete();
        clear_model(0);
        send_hits(0, 0, HIT_NUM, 1'b0, '0);
        wait_words(WORD_NUM);
        // bank 0 again so counts must start from zero
        check_drain(0, 1'b0, 0);
        check("his_num", his_num, 1);
        finish_test("bank_reuse", e);
    endtask

    initial begin
        res       <= 1'b0;
        hit_req   <= 1'b0;
        hit       <= '0;
        out_ack   <= 1'b0;
        ack_delay = 0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        res <= 1'b1;
        fork
            collect_words();
        join_none
        reset_values();
        random_frame();
        single_bin_frame();
        overlapped_slow_drain();
        bank_reuse();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/hist_builder_top.sv
`include "sifh_params.svh"

module hist_builder_top (
    input  logic                      clk,
    input  logic                      res,
    // hit input, four-phase
    input  logic                      hit_req,
    input  sifh_data_pkg::hit_t       hit,
    output logic                      hit_ack,
    // histogram readout, four-phase
    output logic                      out_req,
    output sifh_data_pkg::hist_word_t out_word,
    input  logic                      out_ack,
    // bank currently accumulating
    output logic                      his_num
);
    // sequencer to RAM
    sifh_ctrl_pkg::bank_cmd_t  bank_cmd;
    logic [`CNT_W-1:0]         inc_count;
    logic [`CNT_W-1:0]         rd_count;

    // sequencer to frame counter
    logic                      step;
    sifh_ctrl_pkg::frame_pos_t pos;
    logic                      frame_last;

    // sequencer to readout
    logic                      drain_start;
    logic                      drain_busy;

    // readout to RAM
    sifh_data_pkg::bin_addr_t  rd_addr;
    logic                      rd_clear;
    logic [`CNT_W-1:0]         drain_count;

    hist_sequencer hist_sequencer_i (
        .clk         (clk),
        .res         (res),
        .hit_req     (hit_req),
        .hit         (hit),
        .rd_count    (rd_count),
        .pos         (pos),
        .frame_last  (frame_last),
        .drain_busy  (drain_busy),
        .hit_ack     (hit_ack),
        .bank_cmd    (bank_cmd),
        .inc_count   (inc_count),
        .step        (step),
        .his_num     (his_num),
        .drain_start (drain_start)
    );

    frame_counter frame_counter_i (
        .clk        (clk),
        .res        (res),
        .step       (step),
        .pos        (pos),
        .frame_last (frame_last)
    );

    bin_bank_ram bin_bank_ram_i (
        .clk         (clk),
        .res         (res),
        .his_num     (his_num),
        .bank_cmd    (bank_cmd),
        .inc_count   (inc_count),
        .rd_addr     (rd_addr),
        .rd_clear    (rd_clear),
        .rd_count    (rd_count),
        .drain_count (drain_count)
    );

    hist_readout hist_readout_i (
        .clk         (clk),
        .res         (res),
        .drain_start (drain_start),
        .his_num     (his_num),
        .drain_count (drain_count),
        .out_ack     (out_ack),
        .drain_busy  (drain_busy),
        .rd_addr     (rd_addr),
        .rd_clear    (rd_clear),
        .out_req     (out_req),
        .out_word    (out_word)
    );

endmodule

// File: rtl/hist_readout.sv
`include "sifh_params.svh"

module hist_readout (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      drain_start,
    input  logic                      his_num,
    input  logic [`CNT_W-1:0]         drain_count,
    input  logic                      out_ack,
    output logic                      drain_busy,
    output sifh_data_pkg::bin_addr_t  rd_addr,
    output logic                      rd_clear,
    output logic                      out_req,
    output sifh_data_pkg::hist_word_t out_word
);
    // per-word readout phases
    typedef enum logic [1:0] {
        R_IDLE,
        R_READ,
        R_REQ,
        R_RELEASE
    } rd_state_e;

    rd_state_e state;

    logic bin_last;
    logic word_last;

    // end of a pixel row and end of the bank
    assign bin_last  = (rd_addr.bin == `BIN_W'(`BIN_NUM - 1));
    assign word_last = bin_last && (rd_addr.pixel == `PIXEL_W'(`PIXEL_NUM - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= R_IDLE;
            rd_addr <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    // sweep always starts at pixel 0, bin 0
                    if (drain_start) begin
                        rd_addr <= '0;
                        state   <= R_READ;
                    end
                end
                R_READ: begin
                    // drain_count lands at the end of this cycle
                    state <= R_REQ;
                end
                R_REQ: begin
                    // word is cleared on this edge
                    if (out_ack) begin
                        state <= R_RELEASE;
                    end
                end
                R_RELEASE: begin
                    // wait for the consumer to drop ack
                    if (!out_ack) begin
                        if (word_last) begin
                            state <= R_IDLE;
                        end else begin
                            state <= R_READ;
                            // bin-minor step
                            if (bin_last) begin
                                rd_addr.bin   <= '0;
                                rd_addr.pixel <= rd_addr.pixel + 1'b1;
                            end else begin
                                rd_addr.bin <= rd_addr.bin + 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    // high from drain_start to the end of the last handshake
    assign drain_busy = (state != R_IDLE);

    assign out_req  = (state == R_REQ);
    assign rd_clear = out_req && out_ack;

    // banks cannot swap mid-drain, so the drained bank is ~his_num
    assign out_word.bank  = ~his_num;
    assign out_word.pixel = rd_addr.pixel;
    assign out_word.bin   = rd_addr.bin;
    assign out_word.count = drain_count;

endmodule

// File: rtl/bin_bank_ram.sv
`include "sifh_params.svh"

module bin_bank_ram (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     his_num,
    input  sifh_ctrl_pkg::bank_cmd_t bank_cmd,
    input  logic [`CNT_W-1:0]        inc_count,
    input  sifh_data_pkg::bin_addr_t rd_addr,
    input  logic                     rd_clear,
    output logic [`CNT_W-1:0]        rd_count,
    output logic [`CNT_W-1:0]        drain_count
);
    import sifh_data_pkg::*;
    import sifh_ctrl_pkg::*;

    // counters per bank
    localparam int WORD_NUM = `PIXEL_NUM * `BIN_NUM;

    // counter storage for both banks
    logic [`CNT_W-1:0] mem [2][WORD_NUM];
    // a word counts only while its valid bit is set
    logic [1:0][WORD_NUM-1:0] valid;

    // flat word index of each port
    int  acc_idx;
    int  drn_idx;
    // bank that the drain port works on
    logic drn_bank;

    // pixel-major layout inside a bank
    function automatic int word_idx(input bin_addr_t addr);
        return int'(addr.pixel) * `BIN_NUM + int'(addr.bin);
    endfunction

    always_comb begin
        acc_idx = word_idx(bank_cmd.addr);
        drn_idx = word_idx(rd_addr);
    end

    // drain always reads the bank not accumulating
    assign drn_bank = ~his_num;

    // counter write from the increment
    always_ff @(posedge clk) begin
        if (bank_cmd.op == OP_INC) begin
            mem[his_num][acc_idx] <= inc_count;
        end
    end

    // valid bits
    // set on increment, cleared when the drain port consumes the word
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            valid <= '0;
        end else begin
            if (bank_cmd.op == OP_INC) begin
                valid[his_num][acc_idx] <= 1'b1;
            end
            if (rd_clear) begin
                valid[drn_bank][drn_idx] <= 1'b0;
            end
        end
    end

    // accumulate read, one cycle latency
    // an invalid word reads as zero so no clear sweep is needed
    always_ff @(posedge clk) begin
        if (bank_cmd.op == OP_READ) begin
            if (valid[his_num][acc_idx]) begin
                rd_count <= mem[his_num][acc_idx];
            end else begin
                rd_count <= '0;
            end
        end
    end

    // drain read, runs every cycle from rd_addr
    always_ff @(posedge clk) begin
        if (valid[drn_bank][drn_idx]) begin
            drain_count <= mem[drn_bank][drn_idx];
        end else begin
            drain_count <= '0;
        end
    end

endmodule

// File: rtl/hist_sequencer.sv
`include "sifh_params.svh"

module hist_sequencer (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      hit_req,
    input  sifh_data_pkg::hit_t       hit,
    input  logic [`CNT_W-1:0]         rd_count,
    input  sifh_ctrl_pkg::frame_pos_t pos,
    input  logic                      frame_last,
    input  logic                      drain_busy,
    output logic                      hit_ack,
    output sifh_ctrl_pkg::bank_cmd_t  bank_cmd,
    output logic [`CNT_W-1:0]         inc_count,
    output logic                      step,
    output logic                      his_num,
    output logic                      drain_start
);
    import sifh_ctrl_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    // state and active bank
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= S_IDLE;
            his_num <= 1'b0;
        end else begin
            state <= state_nxt;
            // ping-pong, the filled bank goes to readout
            if (drain_start) begin
                his_num <= ~his_num;
            end
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                // hit is stable once req is seen
                if (hit_req) begin
                    state_nxt = S_READ;
                end
            end
            S_READ: begin
                state_nxt = S_WRITE;
            end
            S_WRITE: begin
                // last hit of the frame detours through the swap
                state_nxt = frame_last ? S_SWAP : S_ACK;
            end
            S_SWAP: begin
                // hold until the previous frame has left the other bank
                if (!drain_busy) begin
                    state_nxt = S_ACK;
                end
            end
            S_ACK: begin
                // four-phase return to zero
                if (!hit_req) begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    // bin being counted, pixel comes from the frame position
    always_comb begin
        bank_cmd.addr.pixel = pos.pixel;
        bank_cmd.addr.bin   = hit.bin;
        case (state)
            S_READ:  bank_cmd.op = OP_READ;
            S_WRITE: bank_cmd.op = OP_INC;
            default: bank_cmd.op = OP_NONE;
        endcase
    end

    // rd_count is valid in S_WRITE, one cycle after the read
    assign inc_count = rd_count + 1'b1;

    // advance the frame position with the write
    assign step = (state == S_WRITE);

    // swap and start draining in the same cycle
    assign drain_start = (state == S_SWAP) && !drain_busy;

    assign hit_ack = (state == S_ACK);

endmodule

// File: rtl/frame_counter.sv
`include "sifh_params.svh"

module frame_counter (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      step,
    output sifh_ctrl_pkg::frame_pos_t pos,
    output logic                      frame_last
);
    // hit index within the current pixel
    logic [`HIT_W-1:0]   hit_idx;
    // pixel index within the current acquisition
    logic [`PIXEL_W-1:0] pixel_idx;
    // acquisition index within the frame
    logic [`ACQ_W-1:0]   acq_idx;

    logic hit_last;
    logic pixel_last;
    logic acq_last;

    // wrap points of each level
    assign hit_last   = (hit_idx == `HIT_W'(`DATA_NUM - 1));
    assign pixel_last = (pixel_idx == `PIXEL_W'(`PIXEL_NUM - 1));
    assign acq_last   = (acq_idx == `ACQ_W'(`ACQ_NUM - 1));

    // nested counters, each level carries into the next
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_idx   <= '0;
            pixel_idx <= '0;
            acq_idx   <= '0;
        end else if (step) begin
            if (!hit_last) begin
                hit_idx <= hit_idx + 1'b1;
            end else begin
                hit_idx <= '0;
                if (!pixel_last) begin
                    pixel_idx <= pixel_idx + 1'b1;
                end else begin
                    pixel_idx <= '0;
                    // end of frame wraps everything to zero
                    if (!acq_last) begin
                        acq_idx <= acq_idx + 1'b1;
                    end else begin
                        acq_idx <= '0;
                    end
                end
            end
        end
    end

    // final hit of the frame
    assign frame_last = hit_last && pixel_last && acq_last;

    assign pos.acq   = acq_idx;
    assign pos.pixel = pixel_idx;
    assign pos.hit   = hit_idx;

endmodule

// File: rtl/sifh_ctrl_pkg.sv
`include "sifh_params.svh"

package sifh_ctrl_pkg;

    // hit sequencer states
    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_SWAP,
        S_ACK
    } seq_state_e;

    // accumulate port opcodes
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_INC
    } bank_op_e;

    // where the current hit sits inside the frame
    typedef struct packed {
        logic [`ACQ_W-1:0]   acq;
        logic [`PIXEL_W-1:0] pixel;
        logic [`HIT_W-1:0]   hit;
    } frame_pos_t;

    // command into the accumulate port of the bank RAM
    typedef struct packed {
        bank_op_e                 op;
        sifh_data_pkg::bin_addr_t addr;
    } bank_cmd_t;

endpackage

// File: rtl/sifh_data_pkg.sv
`include "sifh_params.svh"

package sifh_data_pkg;

    // one photon hit from the pixel front end
    // only the time-bin address travels with it
    typedef struct packed {
        logic [`BIN_W-1:0] bin;
    } hit_t;

    // location of one counter inside a bank
    // pixel-major, bin-minor
    typedef struct packed {
        logic [`PIXEL_W-1:0] pixel;
        logic [`BIN_W-1:0]   bin;
    } bin_addr_t;

    // one histogram word on the readout interface
    typedef struct packed {
        // bank the word was drained from
        logic                bank;
        logic [`PIXEL_W-1:0] pixel;
        logic [`BIN_W-1:0]   bin;
        // number of hits seen in this bin over the frame
        logic [`CNT_W-1:0]   count;
    } hist_word_t;

endpackage

// File: rtl/sifh_params.svh
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// time bins per pixel
`define BIN_NUM 16
// bin address width
`define BIN_W 4

// pixels in the array
`define PIXEL_NUM 3
// pixel index width
`define PIXEL_W 2

// acquisitions in one frame
`define ACQ_NUM 2
// acquisition index width
`define ACQ_W 1

// hits per pixel in one acquisition
`define DATA_NUM 4
// hit index width
`define HIT_W 2

// bin counter width
// a bin holds at most ACQ_NUM * DATA_NUM = 8, so 8 bits never wrap
`define CNT_W 8

`endif
